// File: logic/bridge_pkg.sv
package bridge_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int WORD_W           = 32;
    localparam int PARAM_WORDS      = 2;
    localparam int NUM_REQ_CHANNELS = 4;
    localparam int REQ_IDX_W        = $clog2(NUM_REQ_CHANNELS);

    // host word per core request channel
    // index 0 has the highest priority
    localparam logic [15:0] REQUEST_WORDS [NUM_REQ_CHANNELS] = '{
        16'h0140,
        16'h0141,
        16'h0180,
        16'h0184
    };

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [15:0] {
        host_request_status         = 16'h0000,
        host_reset_enter            = 16'h0010,
        host_reset_exit             = 16'h0011,
        host_dataslot_request_read  = 16'h0080,
        host_dataslot_update        = 16'h008a,
        host_notify_menu_state      = 16'h00b0,
        host_notify_docked_state    = 16'h00b1
    } cmd_word_e;

    // undefined holds a status request open
    typedef enum logic [WORD_W-1:0] {
        status_undefined = 32'h0,
        status_booting   = 32'h1,
        status_setup     = 32'h2,
        status_idle      = 32'h3,
        status_running   = 32'h4
    } request_status_e;

    typedef enum logic [WORD_W-1:0] {
        read_ready_to_read = 32'h0,
        read_not_allowed   = 32'h1,
        read_check_later   = 32'h2
    } dataslot_read_result_e;

    typedef enum logic [2:0] {
        cmd_state_idle                  = 3'd0,
        cmd_state_request_status        = 3'd1,
        cmd_state_dataslot_request_read = 3'd2,
        cmd_state_exit                  = 3'd7
    } cmd_state_e;

    ////////////////////////////////////////
    // port bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic                                valid;
        logic [15:0]                         word;
        logic [PARAM_WORDS-1:0][WORD_W-1:0]  param;
    } cmd_req_t;

    typedef struct packed {
        logic                                ack;
        logic                                done;
        logic [WORD_W-1:0]                   result;
    } cmd_rsp_t;

    typedef struct packed {
        logic [15:0]                         slot_id;
        logic [WORD_W-1:0]                   offset;
        logic [WORD_W-1:0]                   length;
    } dataslot_t;

    typedef struct packed {
        logic                                valid;
        logic [PARAM_WORDS-1:0][WORD_W-1:0]  param;
    } core_req_t;

    typedef struct packed {
        logic                                ack;
        logic                                done;
    } core_rsp_t;

    typedef struct packed {
        logic                                valid;
        logic [15:0]                         word;
        logic [PARAM_WORDS-1:0][WORD_W-1:0]  param;
    } host_req_t;

    typedef struct packed {
        logic                                ack;
        logic                                done;
    } host_rsp_t;

endpackage

// File: logic/bridge_command_decoder.sv
`timescale 1ns/10ps

module bridge_command_decoder (
    input  logic                               bridge,
    input  logic                               arst_n,
    input  bridge_pkg::cmd_req_t               cmd_req,
    input  bridge_pkg::request_status_e        core_status,
    input  logic                               dataslot_read_done,
    input  bridge_pkg::dataslot_read_result_e  dataslot_read_result,
    output bridge_pkg::cmd_rsp_t               cmd_rsp,
    output logic                               reset_n,
    output logic                               in_menu,
    output logic                               docked,
    output logic                               dataslot_update_valid,
    output logic                               dataslot_read_valid,
    output bridge_pkg::dataslot_t              dataslot_param
);

    bridge_pkg::cmd_state_e  state;
    bridge_pkg::dataslot_t   cmd_dataslot;
    logic                    accept;
    logic                    exit_cmd;
    logic                    dataslot_word;

    assign accept = cmd_req.valid && (state == bridge_pkg::cmd_state_idle);

    assign dataslot_word = (cmd_req.word == bridge_pkg::host_dataslot_update) ||
                           (cmd_req.word == bridge_pkg::host_dataslot_request_read);

    // slot id and a short offset share word 0 while length is word 1
    always_comb begin
        cmd_dataslot.slot_id = cmd_req.param[0][15:0];
        cmd_dataslot.offset  = {16'h0000, cmd_req.param[0][31:16]};
        cmd_dataslot.length  = cmd_req.param[1];
    end

    ////////////////////////////////////////
    // command FSM
    ////////////////////////////////////////

    always_ff @(posedge bridge or negedge arst_n) begin
        if (!arst_n) begin
            state                 <= bridge_pkg::cmd_state_idle;
            reset_n               <= 1'b0;
            in_menu               <= 1'b0;
            docked                <= 1'b0;
            dataslot_update_valid <= 1'b0;
            dataslot_read_valid   <= 1'b0;
        end else begin
            // notifications are single cycle
            dataslot_update_valid <= 1'b0;
            dataslot_read_valid   <= 1'b0;

            case (state)
                bridge_pkg::cmd_state_idle: begin
                    if (cmd_req.valid) begin
                        case (cmd_req.word)
                            bridge_pkg::host_request_status: begin
                                state <= bridge_pkg::cmd_state_request_status;
                            end
                            bridge_pkg::host_reset_enter: begin
                                reset_n <= 1'b0;
                                state   <= bridge_pkg::cmd_state_exit;
                            end
                            bridge_pkg::host_reset_exit: begin
                                reset_n <= 1'b1;
                                state   <= bridge_pkg::cmd_state_exit;
                            end
                            bridge_pkg::host_dataslot_request_read: begin
                                dataslot_read_valid <= 1'b1;
                                state <= bridge_pkg::cmd_state_dataslot_request_read;
                            end
                            bridge_pkg::host_dataslot_update: begin
                                dataslot_update_valid <= 1'b1;
                                state <= bridge_pkg::cmd_state_exit;
                            end
                            bridge_pkg::host_notify_menu_state: begin
                                in_menu <= cmd_req.param[0][0];
                                state   <= bridge_pkg::cmd_state_exit;
                            end
                            bridge_pkg::host_notify_docked_state: begin
                                docked <= cmd_req.param[0][0];
                                state  <= bridge_pkg::cmd_state_exit;
                            end
                            default: begin
                                // unknown word, answer with result 0
                                state <= bridge_pkg::cmd_state_exit;
                            end
                        endcase
                    end
                end

                bridge_pkg::cmd_state_request_status,
                bridge_pkg::cmd_state_dataslot_request_read,
                bridge_pkg::cmd_state_exit: begin
                    if (exit_cmd) begin
                        state <= bridge_pkg::cmd_state_idle;
                    end
                end

                default: begin
                    state <= bridge_pkg::cmd_state_idle;
                end
            endcase
        end
    end

    always_ff @(posedge bridge) begin
        if (accept && dataslot_word) begin
            dataslot_param <= cmd_dataslot;
        end
    end

    ////////////////////////////////////////
    // done and result select
    ////////////////////////////////////////

    always_comb begin
        cmd_rsp.ack    = (state == bridge_pkg::cmd_state_idle);
        cmd_rsp.result = '0;
        exit_cmd       = 1'b0;

        case (state)
            bridge_pkg::cmd_state_request_status: begin
                exit_cmd       = (core_status != bridge_pkg::status_undefined);
                cmd_rsp.result = core_status;
            end
            bridge_pkg::cmd_state_dataslot_request_read: begin
                exit_cmd       = dataslot_read_done;
                cmd_rsp.result = dataslot_read_result;
            end
            bridge_pkg::cmd_state_exit: begin
                exit_cmd = 1'b1;
            end
            default: begin
            end
        endcase

        cmd_rsp.done = exit_cmd;
    end

    // the core answers a read only while one is outstanding
    a_read_done_when_waiting: assert property (
        @(posedge bridge) disable iff (!arst_n)
        dataslot_read_done |-> (state == bridge_pkg::cmd_state_dataslot_request_read)
    );

endmodule

// File: logic/request_channel.sv
`timescale 1ns/10ps

module request_channel (
    input  logic                                                   bridge,
    input  logic                                                   arst_n,
    input  bridge_pkg::core_req_t                                  core_req,
    input  logic                                                   grant_ack,
    input  logic                                                   grant_done,
    output bridge_pkg::core_rsp_t                                  core_rsp,
    output logic                                                   pending,
    output logic [bridge_pkg::PARAM_WORDS-1:0][bridge_pkg::WORD_W-1:0] param
);

    logic capture;

    // a new request is taken only once the previous one is finished
    assign capture = core_req.valid && !pending;

    always_ff @(posedge bridge or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (grant_done) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge bridge) begin
        if (capture) begin
            param <= core_req.param;
        end
    end

    // arbiter already qualifies ack and done with this channel's grant
    always_comb begin
        core_rsp.ack  = grant_ack;
        core_rsp.done = grant_done;
    end

    // core keeps its param steady until it has seen done
    a_param_stable: assert property (
        @(posedge bridge) disable iff (!arst_n)
        (pending && !grant_done) |=> $stable(core_req.param)
    );

endmodule

// File: logic/request_arbiter.sv
`timescale 1ns/10ps

module request_arbiter (
    input  logic                                       bridge,
    input  logic                                       arst_n,
    input  logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]    pending,
    input  logic [bridge_pkg::PARAM_WORDS-1:0][bridge_pkg::WORD_W-1:0]
                                                       channel_param [bridge_pkg::NUM_REQ_CHANNELS],
    input  bridge_pkg::host_rsp_t                      host_rsp,
    output bridge_pkg::host_req_t                      host_req,
    output logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]    grant_ack,
    output logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]    grant_done
);

    logic                                     busy;
    logic                                     acked;
    logic [bridge_pkg::REQ_IDX_W-1:0]         sel;
    logic [bridge_pkg::REQ_IDX_W-1:0]         pick;
    logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]  grant;

    ////////////////////////////////////////
    // fixed priority pick
    ////////////////////////////////////////

    // scan down so the lowest pending index is left in pick
    always_comb begin
        pick = '0;
        for (int i = bridge_pkg::NUM_REQ_CHANNELS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = bridge_pkg::REQ_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge bridge or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            acked <= 1'b0;
            sel   <= '0;
        end else if (!busy) begin
            if (|pending) begin
                busy <= 1'b1;
                sel  <= pick;
            end
        end else if (host_rsp.done) begin
            busy  <= 1'b0;
            acked <= 1'b0;
        end else if (host_rsp.ack) begin
            acked <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // host side and grant routing
    ////////////////////////////////////////

    always_comb begin
        grant = '0;
        if (busy) begin
            grant[sel] = 1'b1;
        end
    end

    always_comb begin
        host_req.valid = busy && !acked;
        host_req.word  = busy ? bridge_pkg::REQUEST_WORDS[sel] : '0;
        host_req.param = busy ? channel_param[sel] : '0;
    end

    assign grant_ack  = grant & {bridge_pkg::NUM_REQ_CHANNELS{host_rsp.ack}};
    assign grant_done = grant & {bridge_pkg::NUM_REQ_CHANNELS{host_rsp.done}};

    // host done only ever answers a granted request
    a_done_onehot: assert property (
        @(posedge bridge) disable iff (!arst_n)
        host_rsp.done |-> $onehot(grant_done)
    );

    // back-pressure holds the request until the host acks it
    a_req_held: assert property (
        @(posedge bridge) disable iff (!arst_n)
        (host_req.valid && !host_rsp.ack) |=>
            host_req.valid && $stable(host_req.word) && $stable(host_req.param)
    );

endmodule

// File: logic/bridge_command.sv
`timescale 1ns/10ps

module bridge_command (
    input  logic                                bridge,
    input  logic                                arst_n,

    // host command side
    input  bridge_pkg::cmd_req_t                cmd_req,
    output bridge_pkg::cmd_rsp_t                cmd_rsp,
    input  bridge_pkg::request_status_e         core_status,
    input  logic                                dataslot_read_done,
    input  bridge_pkg::dataslot_read_result_e   dataslot_read_result,
    output logic                                reset_n,
    output logic                                in_menu,
    output logic                                docked,
    output logic                                dataslot_update_valid,
    output logic                                dataslot_read_valid,
    output bridge_pkg::dataslot_t               dataslot_param,

    // core request side
    input  bridge_pkg::core_req_t               core_req [bridge_pkg::NUM_REQ_CHANNELS],
    output bridge_pkg::core_rsp_t               core_rsp [bridge_pkg::NUM_REQ_CHANNELS],
    output bridge_pkg::host_req_t               host_req,
    input  bridge_pkg::host_rsp_t               host_rsp
);

    logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]  pending;
    logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]  grant_ack;
    logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]  grant_done;
    logic [bridge_pkg::PARAM_WORDS-1:0][bridge_pkg::WORD_W-1:0]
                                              channel_param [bridge_pkg::NUM_REQ_CHANNELS];

    bridge_command_decoder i_decoder (
        .bridge,
        .arst_n,
        .cmd_req,
        .core_status,
        .dataslot_read_done,
        .dataslot_read_result,
        .cmd_rsp,
        .reset_n,
        .in_menu,
        .docked,
        .dataslot_update_valid,
        .dataslot_read_valid,
        .dataslot_param
    );

    // index order is priority order as in REQUEST_WORDS
    for (genvar i = 0; i < bridge_pkg::NUM_REQ_CHANNELS; i++) begin : g_channel
        request_channel i_channel (
            .bridge,
            .arst_n,
            .core_req   (core_req[i]),
            .grant_ack  (grant_ack[i]),
            .grant_done (grant_done[i]),
            .core_rsp   (core_rsp[i]),
            .pending    (pending[i]),
            .param      (channel_param[i])
        );
    end

    request_arbiter i_arbiter (
        .bridge,
        .arst_n,
        .pending,
        .channel_param,
        .host_rsp,
        .host_req,
        .grant_ack,
        .grant_done
    );

endmodule

// File: dv/bridge_command_tb.sv
`timescale 1ns/10ps

module bridge_command_tb;

    logic                                  bridge;
    logic                                  arst_n;
    bridge_pkg::cmd_req_t                  cmd_req;
    bridge_pkg::cmd_rsp_t                  cmd_rsp;
    bridge_pkg::request_status_e           core_status;
    logic                                  dataslot_read_done;
    bridge_pkg::dataslot_read_result_e     dataslot_read_result;
    logic                                  reset_n;
    logic                                  in_menu;
    logic                                  docked;
    logic                                  dataslot_update_valid;
    logic                                  dataslot_read_valid;
    bridge_pkg::dataslot_t                 dataslot_param;
    bridge_pkg::core_req_t                 core_req [bridge_pkg::NUM_REQ_CHANNELS];
    bridge_pkg::core_rsp_t                 core_rsp [bridge_pkg::NUM_REQ_CHANNELS];
    bridge_pkg::host_req_t                 host_req;
    bridge_pkg::host_rsp_t                 host_rsp;

    integer seed;
    int     cycles;
    int     cycle_limit;

    // one entry per line of the case file
    bit           is_req_q [$];
    logic [15:0]  word_q [$];
    logic [31:0]  param_q [$];
    int           delay_q [$];
    logic [31:0]  answer_q [$];
    logic [31:0]  result_q [$];
    logic [2:0]   levels_q [$];
    logic [63:0]  words_q [$];

    bridge_command i_dut (
        .bridge,
        .arst_n,
        .cmd_req,
        .cmd_rsp,
        .core_status,
        .dataslot_read_done,
        .dataslot_read_result,
        .reset_n,
        .in_menu,
        .docked,
        .dataslot_update_valid,
        .dataslot_read_valid,
        .dataslot_param,
        .core_req,
        .core_rsp,
        .host_req,
        .host_rsp
    );

    always #20 bridge = ~bridge;

    always @(posedge bridge) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("timeout: run did not end within %0d cycles", cycle_limit));
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_rsp(input string name, input bridge_pkg::cmd_rsp_t got,
                               input bridge_pkg::cmd_rsp_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_status(input string name, input bridge_pkg::request_status_e got,
                                  input bridge_pkg::request_status_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_host_req(input string name, input bridge_pkg::host_req_t got,
                                    input bridge_pkg::host_req_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_dataslot(input string name, input bridge_pkg::dataslot_t got,
                                    input bridge_pkg::dataslot_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // levels is {reset_n, in_menu, docked}
    task automatic check_idle_outputs(input logic [2:0] levels);
        @(negedge bridge);
        compare_level("cmd_rsp.ack", cmd_rsp.ack, 1'b1);
        compare_level("cmd_rsp.done", cmd_rsp.done, 1'b0);
        compare_level("dataslot_update_valid", dataslot_update_valid, 1'b0);
        compare_level("dataslot_read_valid", dataslot_read_valid, 1'b0);
        compare_level("reset_n", reset_n, levels[2]);
        compare_level("in_menu", in_menu, levels[1]);
        compare_level("docked", docked, levels[0]);
        compare_level("host_req.valid", host_req.valid, 1'b0);
        @(posedge bridge);
        #2;
    endtask

    ////////////////////////////////////////
    // host command model
    ////////////////////////////////////////

    task automatic run_cmd(input logic [15:0] word, input logic [31:0] p0, input int delay,
                           input logic [31:0] answer, input logic [31:0] exp_result);
        bridge_pkg::cmd_rsp_t   exp_rsp;
        bridge_pkg::dataslot_t  exp_slot;
        logic                   is_read;
        logic                   is_update;
        logic                   is_status;
        is_read   = (word == bridge_pkg::host_dataslot_request_read);
        is_update = (word == bridge_pkg::host_dataslot_update);
        is_status = (word == bridge_pkg::host_request_status);
        // slot id in the low half of word 0 and offset in its high half
        exp_slot.slot_id = p0[15:0];
        exp_slot.offset  = {16'h0000, p0[31:16]};
        exp_slot.length  = ~p0;
        exp_rsp.ack      = 1'b0;
        exp_rsp.done     = 1'b1;
        exp_rsp.result   = exp_result;

        cmd_req.valid    = 1'b1;
        cmd_req.word     = word;
        cmd_req.param[0] = p0;
        cmd_req.param[1] = ~p0;
        @(negedge bridge);
        while (!cmd_rsp.ack) begin
            @(negedge bridge);
        end
        @(posedge bridge);
        #2;
        cmd_req.valid = 1'b0;

        // first cycle after acceptance
        @(negedge bridge);
        compare_level("dataslot_read_valid", dataslot_read_valid, is_read);
        compare_level("dataslot_update_valid", dataslot_update_valid, is_update);
        if (is_read || is_update) begin
            compare_dataslot("dataslot_param", dataslot_param, exp_slot);
        end

        if (is_read || is_status) begin
            compare_level("cmd_rsp.done", cmd_rsp.done, 1'b0);
            repeat (delay - 1) begin
                @(negedge bridge);
                compare_level("cmd_rsp.done", cmd_rsp.done, 1'b0);
                compare_level("dataslot_read_valid", dataslot_read_valid, 1'b0);
            end
            @(posedge bridge);
            #2;
            if (is_read) begin
                dataslot_read_result = bridge_pkg::dataslot_read_result_e'(answer);
                dataslot_read_done   = 1'b1;
            end else begin
                core_status = bridge_pkg::request_status_e'(answer);
            end
            @(negedge bridge);
            while (!cmd_rsp.done) begin
                @(negedge bridge);
            end
            if (is_status) begin
                compare_status("cmd_rsp.result", bridge_pkg::request_status_e'(cmd_rsp.result),
                               bridge_pkg::request_status_e'(exp_result));
            end
            compare_rsp("cmd_rsp", cmd_rsp, exp_rsp);
            @(posedge bridge);
            #2;
            dataslot_read_done = 1'b0;
            core_status        = bridge_pkg::status_undefined;
        end else begin
            compare_rsp("cmd_rsp", cmd_rsp, exp_rsp);
            @(posedge bridge);
            #2;
        end
    endtask

    ////////////////////////////////////////
    // core and host request models
    ////////////////////////////////////////

    function automatic logic [bridge_pkg::PARAM_WORDS-1:0][bridge_pkg::WORD_W-1:0] make_param(
        input logic [31:0] base, input int ch);
        logic [bridge_pkg::PARAM_WORDS-1:0][bridge_pkg::WORD_W-1:0] p;
        p[0] = base + 32'(ch);
        p[1] = {base[15:0], base[31:16]} ^ {ch[7:0], 24'h000000};
        return p;
    endfunction

    // lowest index wins
    function automatic int first_pending(input logic [bridge_pkg::NUM_REQ_CHANNELS-1:0] mask);
        for (int i = 0; i < bridge_pkg::NUM_REQ_CHANNELS; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic run_req(input logic [bridge_pkg::NUM_REQ_CHANNELS-1:0] mask,
                           input logic [31:0] base, input int done_delay,
                           input logic [63:0] exp_words);
        bridge_pkg::host_req_t                    exp_req;
        logic [bridge_pkg::NUM_REQ_CHANNELS-1:0]  remaining;
        int                                       count;
        int                                       idx;
        int                                       ack_wait;
        count = $countones(mask);
        for (int i = 0; i < bridge_pkg::NUM_REQ_CHANNELS; i++) begin
            if (mask[i]) begin
                core_req[i].valid = 1'b1;
                core_req[i].param = make_param(base, i);
            end
        end
        remaining = mask;

        for (int k = 0; k < count; k++) begin
            idx           = first_pending(remaining);
            exp_req.valid = 1'b1;
            exp_req.word  = exp_words[(count - 1 - k) * 16 +: 16];
            exp_req.param = make_param(base, idx);
            @(negedge bridge);
            while (!host_req.valid) begin
                @(negedge bridge);
            end
            ack_wait = {$random(seed)} % 4;
            repeat (ack_wait) begin
                compare_host_req("host_req", host_req, exp_req);
                @(negedge bridge);
            end
            compare_host_req("host_req", host_req, exp_req);
            @(posedge bridge);
            #2;
            host_rsp.ack  = 1'b1;
            host_rsp.done = (done_delay == 0);
            @(negedge bridge);
            compare_host_req("host_req", host_req, exp_req);
            compare_level($sformatf("core_rsp[%0d].ack", idx), core_rsp[idx].ack, 1'b1);
            if (done_delay > 0) begin
                compare_level($sformatf("core_rsp[%0d].done", idx), core_rsp[idx].done, 1'b0);
                @(posedge bridge);
                #2;
                host_rsp.ack = 1'b0;
                repeat (done_delay - 1) begin
                    @(negedge bridge);
                    compare_level("host_req.valid", host_req.valid, 1'b0);
                    compare_level($sformatf("core_rsp[%0d].done", idx), core_rsp[idx].done, 1'b0);
                    @(posedge bridge);
                    #2;
                end
                host_rsp.done = 1'b1;
                @(negedge bridge);
                compare_level("host_req.valid", host_req.valid, 1'b0);
            end
            for (int j = 0; j < bridge_pkg::NUM_REQ_CHANNELS; j++) begin
                compare_level($sformatf("core_rsp[%0d].done", j), core_rsp[j].done, j == idx);
            end
            @(posedge bridge);
            #2;
            host_rsp            = '0;
            core_req[idx].valid = 1'b0;
            remaining[idx]      = 1'b0;
        end

        // a lost or repeated request would show up here
        repeat (4) begin
            @(negedge bridge);
            compare_level("host_req.valid", host_req.valid, 1'b0);
        end
        @(posedge bridge);
        #2;
    endtask

    ////////////////////////////////////////
    // case file and main sequence
    ////////////////////////////////////////

    task automatic read_cases();
        int           fd;
        int           fields;
        string        line;
        string        kind;
        logic [15:0]  word;
        logic [31:0]  param;
        int           delay;
        logic [31:0]  answer;
        logic [31:0]  result;
        logic [2:0]   levels;
        logic [63:0]  words;
        fd = $fopen("dv/bridge_command_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open dv/bridge_command_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %d %h %h %h %h",
                             kind, word, param, delay, answer, result, levels, words);
            if (fields != 8 || (kind != "cmd" && kind != "req")) begin
                stop_with_failure($sformatf("malformed line in case file: %s", line));
            end
            is_req_q.push_back(kind == "req");
            word_q.push_back(word);
            param_q.push_back(param);
            delay_q.push_back(delay);
            answer_q.push_back(answer);
            result_q.push_back(result);
            levels_q.push_back(levels);
            words_q.push_back(words);
        end
        $fclose(fd);
    endtask

    initial begin
        bridge               = 1'b0;
        arst_n               = 1'b0;
        seed                 = 32'h329;
        cycles               = 0;
        cycle_limit          = 64;
        cmd_req              = '0;
        core_status          = bridge_pkg::status_undefined;
        dataslot_read_done   = 1'b0;
        dataslot_read_result = bridge_pkg::read_ready_to_read;
        host_rsp             = '0;
        for (int i = 0; i < bridge_pkg::NUM_REQ_CHANNELS; i++) begin
            core_req[i] = '0;
        end

        read_cases();
        cycle_limit = 64 * (is_req_q.size() + 1);

        repeat (2) @(posedge bridge);
        #2;
        arst_n = 1'b1;
        check_idle_outputs(3'b000);

        for (int n = 0; n < is_req_q.size(); n++) begin
            if (is_req_q[n]) begin
                run_req(word_q[n][bridge_pkg::NUM_REQ_CHANNELS-1:0], param_q[n], delay_q[n],
                        words_q[n]);
            end else begin
                run_cmd(word_q[n], param_q[n], delay_q[n], answer_q[n], result_q[n]);
            end
            check_idle_outputs(levels_q[n]);
        end

        if (is_req_q.size() == 0) begin
            stop_with_failure("no test cases found in the case file");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
logic/bridge_pkg.sv
logic/bridge_command_decoder.sv
logic/request_channel.sv
logic/request_arbiter.sv
logic/bridge_command.sv
dv/bridge_command_tb.sv

// File: dv/bridge_command_cases.txt
# kind word/mask param0 delay answer result levels host_words (all hex except delay)
# levels = {reset_n,in_menu,docked}; delay = core answer wait (cmd) or host done after ack (req)
cmd 0010 00000000 0 00000000 00000000 0 0
cmd 0011 00000000 0 00000000 00000000 4 0
cmd 00b0 00000001 0 00000000 00000000 6 0
cmd 00b1 00000003 0 00000000 00000000 7 0
cmd 00b0 00000002 0 00000000 00000000 5 0
cmd 1234 ffffffff 0 00000000 00000000 5 0
cmd 0000 00000000 3 00000001 00000001 5 0
cmd 0000 00000000 1 00000004 00000004 5 0
cmd 0000 00000000 6 00000003 00000003 5 0
cmd 0080 00200005 2 00000002 00000002 5 0
cmd 0080 0000abcd 1 00000000 00000000 5 0
cmd 0080 12340042 4 00000001 00000001 5 0
cmd 008a 00100007 0 00000000 00000000 5 0
cmd 00b1 00000000 0 00000000 00000000 4 0
cmd 0010 00000000 0 00000000 00000000 0 0
cmd 0011 00000000 0 00000000 00000000 4 0
req f 10000000 0 00000000 00000000 4 0140014101800184
req 5 20000010 2 00000000 00000000 4 01400180
req a 3000abc0 1 00000000 00000000 4 01410184
req 8 40000100 0 00000000 00000000 4 0184
req 6 5a5a0000 3 00000000 00000000 4 01410180
req 1 6000f000 1 00000000 00000000 4 0140
req f 7fff0000 2 00000000 00000000 4 0140014101800184
cmd 0000 00000000 2 00000002 00000002 4 0
req c 80000001 0 00000000 00000000 4 01800184
req 3 9000c0de 1 00000000 00000000 4 01400141
cmd 00b0 00000001 0 00000000 00000000 6 0
req 9 a0000aa0 0 00000000 00000000 6 01400184
req f b0001234 1 00000000 00000000 6 0140014101800184
